// ==== rtl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  // data widths
  localparam int pix_w   = 8;   // pixel brightness
  localparam int coeff_w = 18;  // coefficient word, sign included
  localparam int prod_w  = 26;  // 8 bit unsigned times 18 bit signed needs 26 bits
  localparam int acc_w   = 48;  // cascade partial sum

  typedef logic        [pix_w-1:0]   pixel_t; // unsigned brightness
  typedef logic signed [coeff_w-1:0] coeff_t; // s.int.frac fixed point
  typedef logic signed [prod_w-1:0]  prod_t;  // pixel times coefficient
  typedef logic signed [acc_w-1:0]   acc_t;   // running window sum

  // window geometry
  localparam int win_size = 5;                   // window edge
  localparam int num_taps = win_size * win_size; // one tap per window position
  localparam int row_skew = win_size;            // extra delay per row, in samples

  // coefficient format: sign, coeff_int_bits integer bits, the rest fraction
  localparam int coeff_int_bits  = 1;                    // erb
  localparam int coeff_frac_bits = 17 - coeff_int_bits;  // 16 -> 1.0 = 65536

  // output pixel = integer part of the sum, so drop the fraction bits
  localparam int out_lsb = coeff_frac_bits;

  // smoothing kernel in 1/256 steps, scaled to Q16 (x256)
  //   -1   0   2   0  -1
  //    0  12  24  12   0
  //    2  24 108  24   2
  //    0  12  24  12   0
  //   -1   0   2   0  -1
  // weights sum to 256/256 = 1.0, symmetric in both axes
  // tap index = 5*row + column, column 4 is the newest sample
  localparam coeff_t coeff_table [num_taps] = '{
    // row 0
    -18'sd256,  18'sd0,     18'sd512,   18'sd0,     -18'sd256,
    // row 1
    18'sd0,     18'sd3072,  18'sd6144,  18'sd3072,  18'sd0,
    // row 2, center tap is index 12
    18'sd512,   18'sd6144,  18'sd27648, 18'sd6144,  18'sd512,
    // row 3
    18'sd0,     18'sd3072,  18'sd6144,  18'sd3072,  18'sd0,
    // row 4
    -18'sd256,  18'sd0,     18'sd512,   18'sd0,     -18'sd256
  };

endpackage

`default_nettype wire

// ==== rtl/row_skew_line.sv ====
`default_nettype none

// delays one pixel row so the rows line up in the cascade
// row r needs r*row_skew samples of delay, row 0 needs none
module row_skew_line #(
  parameter int depth = 5  // delay in samples, >= 1
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire conv_pkg::pixel_t pix_in,   // undelayed row sample
  output conv_pkg::pixel_t      pix_out   // sample from depth clocks ago
);

  // shift register, entry 0 is the newest sample
  conv_pkg::pixel_t shreg [depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        shreg[i] <= '0;                // flush the line, window sees black
      end
    end else begin
      shreg[0] <= pix_in;              // take a new sample every clock
      for (int i = 1; i < depth; i++) begin
        shreg[i] <= shreg[i-1];        // move everything one slot older
      end
    end
  end

  // oldest entry leaves the line
  assign pix_out = shreg[depth-1];

endmodule

`default_nettype wire

// ==== rtl/mac_tap.sv ====
`default_nettype none

// one stage of the systolic MAC chain
// pixel reg -> product reg -> sum reg, 3 clocks from pix_in to cascade_out
// the one-clock sum step between taps turns the taps of a row into columns
module mac_tap #(
  parameter int tap_index = 0  // window position, 0..num_taps-1
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire conv_pkg::pixel_t pix_in,      // aligned row sample
  input  wire conv_pkg::acc_t   cascade_in,  // partial sum of the previous tap
  output conv_pkg::acc_t        cascade_out  // partial sum incl. this tap
);

  // fixed weight of this window position
  localparam conv_pkg::coeff_t coeff = conv_pkg::coeff_table[tap_index];

  conv_pkg::pixel_t pix_q;   // registered pixel
  conv_pkg::prod_t  prod_q;  // registered product
  conv_pkg::acc_t   sum_q;   // registered partial sum

  // stage 1 and 2: capture pixel, then multiply
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_q  <= '0;
      prod_q <= '0;
    end else begin
      pix_q  <= pix_in;
      // pixel is unsigned, so zero extend before the signed multiply
      prod_q <= conv_pkg::prod_t'($signed({1'b0, pix_q})) * conv_pkg::prod_t'(coeff);
    end
  end

  // stage 3: accumulate
  generate
    if (tap_index == 0) begin : g_first
      // head of the chain, nothing upstream to add
      always_ff @(posedge clk) begin
        if (rst) begin
          sum_q <= '0;
        end else begin
          sum_q <= conv_pkg::acc_t'(prod_q);  // sign extend to 48 bits
        end
      end
    end else begin : g_chain
      always_ff @(posedge clk) begin
        if (rst) begin
          sum_q <= '0;
        end else begin
          sum_q <= conv_pkg::acc_t'(prod_q) + cascade_in;  // product on top of upstream sum
        end
      end
    end
  endgenerate

  assign cascade_out = sum_q;

endmodule

`default_nettype wire

// ==== rtl/mac_cascade.sv ====
`default_nettype none

// 25 cascaded taps forming the 5x5 window
// tap i = 5*row + column, fed by aligned row i/5
// sum of the last tap holds the whole window, output takes its integer bits
//
// latency from row r sample to pix_out, column c (4 = newest):
//   skew 5r + product/sum 2 + chain steps (24 - 5r - c) + output reg 1
//   = 27 - c clocks, so 23 for the newest and 27 for the oldest column
module mac_cascade (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire conv_pkg::pixel_t row0_al,  // row 0, no skew
  input  wire conv_pkg::pixel_t row1_al,  // row 1, 5 samples late
  input  wire conv_pkg::pixel_t row2_al,  // row 2, 10 samples late
  input  wire conv_pkg::pixel_t row3_al,  // row 3, 15 samples late
  input  wire conv_pkg::pixel_t row4_al,  // row 4, 20 samples late
  output conv_pkg::pixel_t      pix_out   // filtered pixel
);

  localparam int n = conv_pkg::num_taps;

  conv_pkg::pixel_t rows_al  [conv_pkg::win_size];  // aligned rows, indexable
  conv_pkg::acc_t   casc_in  [n];                   // cascade input per tap
  conv_pkg::acc_t   tap_sum  [n];                   // cascade output per tap
  conv_pkg::pixel_t pix_q;                          // output pixel register

  assign rows_al[0] = row0_al;
  assign rows_al[1] = row1_al;
  assign rows_al[2] = row2_al;
  assign rows_al[3] = row3_al;
  assign rows_al[4] = row4_al;

  generate
    for (genvar i = 0; i < n; i++) begin : g_tap
      // chain link, tap 0 has no upstream neighbor
      if (i == 0) begin : g_head
        assign casc_in[i] = '0;
      end else begin : g_link
        assign casc_in[i] = tap_sum[i-1];
      end

      mac_tap #(
        .tap_index (i)
      ) u_tap (
        .clk         (clk),
        .rst         (rst),
        .pix_in      (rows_al[i / conv_pkg::win_size]),  // all 5 taps of a row share it
        .cascade_in  (casc_in[i]),
        .cascade_out (tap_sum[i])
      );
    end
  endgenerate

  // integer part of the window sum, fraction bits dropped
  // sum[out_lsb+7 : out_lsb], no saturation
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_q <= '0;
    end else begin
      pix_q <= tap_sum[n-1][conv_pkg::out_lsb +: conv_pkg::pix_w];
    end
  end

  assign pix_out = pix_q;

endmodule

`default_nettype wire

// ==== rtl/conv5x5_top.sv ====
`default_nettype none

// streaming 5x5 convolution, five rows in, one filtered pixel out per clock
// rows 1..4 get skewed so every row arrives at its own taps in step
module conv5x5_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire conv_pkg::pixel_t row0,     // topmost row of the window
  input  wire conv_pkg::pixel_t row1,
  input  wire conv_pkg::pixel_t row2,
  input  wire conv_pkg::pixel_t row3,
  input  wire conv_pkg::pixel_t row4,     // bottom row
  output conv_pkg::pixel_t      pix_out   // filtered pixel
);

  // skewed rows, row 0 goes straight through
  conv_pkg::pixel_t row1_al;
  conv_pkg::pixel_t row2_al;
  conv_pkg::pixel_t row3_al;
  conv_pkg::pixel_t row4_al;

  row_skew_line #(
    .depth (1 * conv_pkg::row_skew)  // 5
  ) u_skew1 (
    .clk     (clk),
    .rst     (rst),
    .pix_in  (row1),
    .pix_out (row1_al)
  );

  row_skew_line #(
    .depth (2 * conv_pkg::row_skew)  // 10
  ) u_skew2 (
    .clk     (clk),
    .rst     (rst),
    .pix_in  (row2),
    .pix_out (row2_al)
  );

  row_skew_line #(
    .depth (3 * conv_pkg::row_skew)  // 15
  ) u_skew3 (
    .clk     (clk),
    .rst     (rst),
    .pix_in  (row3),
    .pix_out (row3_al)
  );

  row_skew_line #(
    .depth (4 * conv_pkg::row_skew)  // 20
  ) u_skew4 (
    .clk     (clk),
    .rst     (rst),
    .pix_in  (row4),
    .pix_out (row4_al)
  );

  mac_cascade u_cascade (
    .clk     (clk),
    .rst     (rst),
    .row0_al (row0),
    .row1_al (row1_al),
    .row2_al (row2_al),
    .row3_al (row3_al),
    .row4_al (row4_al),
    .pix_out (pix_out)
  );

endmodule

`default_nettype wire

// ==== include/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// reference model of the filter
// push_samples() once per clock with the samples taken at that edge,
// expected_pixel() then gives pix_out as seen after the same edge

localparam int hist_len = 28;  // ages 0..27, oldest column needs age 27

conv_pkg::pixel_t hist [conv_pkg::win_size][hist_len];  // [row][age], age 0 newest

function automatic void clear_history();
  foreach (hist[r, a]) hist[r][a] = '0;  // same as a flushed pipeline
endfunction

function automatic void push_samples(conv_pkg::pixel_t r0, conv_pkg::pixel_t r1,
                                     conv_pkg::pixel_t r2, conv_pkg::pixel_t r3,
                                     conv_pkg::pixel_t r4);
  for (int r = 0; r < conv_pkg::win_size; r++) begin
    for (int a = hist_len - 1; a > 0; a--) begin
      hist[r][a] = hist[r][a-1];  // age every sample by one
    end
  end
  hist[0][0] = r0;
  hist[1][0] = r1;
  hist[2][0] = r2;
  hist[3][0] = r3;
  hist[4][0] = r4;
endfunction

// column c of row r was sampled 27 - c clocks ago
function automatic conv_pkg::pixel_t expected_pixel();
  conv_pkg::acc_t sum;
  sum = '0;
  for (int r = 0; r < conv_pkg::win_size; r++) begin
    for (int c = 0; c < conv_pkg::win_size; c++) begin
      sum += conv_pkg::acc_t'(conv_pkg::coeff_table[conv_pkg::win_size * r + c])
           * conv_pkg::acc_t'({1'b0, hist[r][hist_len - 1 - c]});
    end
  end
  return sum[conv_pkg::out_lsb +: conv_pkg::pix_w];  // integer bits only
endfunction

`endif

// ==== testbench/tb_conv5x5.sv ====
`default_nettype none

module tb_conv5x5;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          reset_cycles  = 16;    // initial reset length
  localparam int          wait_limit    = 64;    // max cycles of any wait loop
  localparam int          idle_cycles   = 40;    // zero rows, longer than the window
  localparam int          stream_cycles = 2500;  // random traffic length
  localparam logic [31:0] rng_seed      = 32'h37e1_9fee;

  logic             clk;
  logic             rst;
  conv_pkg::pixel_t row0;
  conv_pkg::pixel_t row1;
  conv_pkg::pixel_t row2;
  conv_pkg::pixel_t row3;
  conv_pkg::pixel_t row4;
  conv_pkg::pixel_t pix_out;

  logic [31:0] rng_state;       // xorshift state
  int          mismatch_count;
  int          timeout_count;
  int          check_count;

  // window history, updated on every edge
  `include "conv_model.svh"

  conv5x5_top DUT (
    .clk     (clk),
    .rst     (rst),
    .row0    (row0),
    .row1    (row1),
    .row2    (row2),
    .row3    (row3),
    .row4    (row4),
    .pix_out (pix_out)
  );

  always #20 clk = ~clk;  // 40 ns period

  // 32 bit xorshift, shifts 13/17/5
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_pixel(output conv_pkg::pixel_t p);
    rng_state = xorshift32(rng_state);
    p = rng_state[15:8];  // middle byte of the state
  endtask

  task automatic check_pixel(string name, conv_pkg::pixel_t expected,
                             conv_pkg::pixel_t actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("[FAIL] %s: expected %0d, actual %0d (t=%0t)", name, expected, actual, $time);
    end
  endtask

  task automatic drive_rows(conv_pkg::pixel_t v0, conv_pkg::pixel_t v1, conv_pkg::pixel_t v2,
                            conv_pkg::pixel_t v3, conv_pkg::pixel_t v4);
    row0 = v0;
    row1 = v1;
    row2 = v2;
    row3 = v3;
    row4 = v4;
  endtask

  task automatic drive_random();
    draw_pixel(row0);
    draw_pixel(row1);
    draw_pixel(row2);
    draw_pixel(row3);
    draw_pixel(row4);
  endtask

  // one clock: track the edge in the model, compare, return 2 ns after the edge
  task automatic step(string name);
    @(posedge clk);
    if (rst) begin
      clear_history();                              // registers flush on this edge
    end else begin
      push_samples(row0, row1, row2, row3, row4);  // what the DUT sampled
    end
    #1;
    check_pixel(name, expected_pixel(), pix_out);
    #1;                                            // next drive point
  endtask

  // after reset release, wait for the output to sit at 0
  task automatic wait_output_zero();
    int  n;
    bit  cleared;
    n = 0;
    cleared = 1'b0;
    while (!cleared && n < wait_limit) begin
      step("reset_release");
      n++;
      if (pix_out === '0) cleared = 1'b1;
    end
    if (!cleared) begin
      timeout_count++;
      $display("timeout: output not back at 0 within %0d cycles of reset", wait_limit);
    end
  endtask

  // single 255 sample on row r, output must follow that row's five weights
  task automatic impulse_test(int r);
    conv_pkg::acc_t   prod;
    conv_pkg::pixel_t exp_pix;
    string            name;
    name = $sformatf("impulse_row%0d", r);
    drive_rows(r == 0 ? 8'd255 : 8'd0, r == 1 ? 8'd255 : 8'd0, r == 2 ? 8'd255 : 8'd0,
               r == 3 ? 8'd255 : 8'd0, r == 4 ? 8'd255 : 8'd0);
    for (int d = 0; d <= 32; d++) begin
      step(name);
      if (d == 0) drive_rows('0, '0, '0, '0, '0);  // impulse taken at d = 0
      if (d >= 23 && d <= 27) begin
        // d cycles late means column 27 - d of row r
        prod = conv_pkg::acc_t'(conv_pkg::coeff_table[conv_pkg::win_size * r + 27 - d])
             * conv_pkg::acc_t'(255);
        exp_pix = prod[conv_pkg::out_lsb +: conv_pkg::pix_w];
      end else begin
        exp_pix = '0;
      end
      check_pixel(name, exp_pix, pix_out);
    end
  endtask

  // constant field, steady output = level times kernel sum
  task automatic flat_test();
    conv_pkg::pixel_t level;
    conv_pkg::pixel_t flat_pix;
    conv_pkg::acc_t   coeff_sum;
    conv_pkg::acc_t   flat_sum;
    int               n;
    bit               settled;
    draw_pixel(level);
    coeff_sum = '0;
    for (int i = 0; i < conv_pkg::num_taps; i++) begin
      coeff_sum += conv_pkg::acc_t'(conv_pkg::coeff_table[i]);
    end
    flat_sum = coeff_sum * conv_pkg::acc_t'(level);     // level zero extends
    flat_pix = flat_sum[conv_pkg::out_lsb +: conv_pkg::pix_w];
    drive_rows(level, level, level, level, level);
    n = 0;
    settled = 1'b0;
    while (!settled && n < wait_limit) begin
      step("flat_fill");
      n++;
      if (pix_out == flat_pix) settled = 1'b1;
    end
    if (!settled) begin
      timeout_count++;
      $display("timeout: flat field output never reached %0d (level %0d)", flat_pix, level);
    end
    for (int i = 0; i < 20; i++) begin
      step("flat_model");
      check_pixel("flat_steady", flat_pix, pix_out);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    drive_rows('0, '0, '0, '0, '0);
    rng_state = rng_seed;
    mismatch_count = 0;
    timeout_count = 0;
    check_count = 0;
    clear_history();

    // reset, output held at 0
    for (int i = 0; i < reset_cycles; i++) begin
      step("reset");
      check_pixel("reset_zero", '0, pix_out);
    end
    rst = 1'b0;
    wait_output_zero();

    // zero rows after reset
    for (int i = 0; i < idle_cycles; i++) begin
      step("idle");
      check_pixel("idle_zero", '0, pix_out);
    end

    for (int r = 0; r < conv_pkg::win_size; r++) begin
      impulse_test(r);
    end

    flat_test();

    // long random run against the model
    for (int i = 0; i < stream_cycles; i++) begin
      drive_random();
      step("random_stream");
    end

    // reset in the middle of traffic, then black rows
    rst = 1'b1;
    for (int i = 0; i < 4; i++) begin
      drive_random();                        // traffic keeps running under reset
      step("mid_reset");
      check_pixel("mid_reset_zero", '0, pix_out);
    end
    drive_rows('0, '0, '0, '0, '0);
    rst = 1'b0;
    wait_output_zero();
    for (int i = 0; i < idle_cycles; i++) begin
      step("post_reset");
      check_pixel("post_reset_zero", '0, pix_out);
    end

    $display("errors: %0d mismatches, %0d timeouts in %0d checks",
             mismatch_count, timeout_count, check_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/conv_pkg.sv
rtl/row_skew_line.sv
rtl/mac_tap.sv
rtl/mac_cascade.sv
rtl/conv5x5_top.sv
testbench/tb_conv5x5.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the 5x5 convolution testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
sim_exe=sim_conv5x5
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_conv5x5 \
  -Mdir "$build_dir" -o "$sim_exe" \
  -f vlog.f

"./$build_dir/$sim_exe" | tee "$log_file"

if grep -q "Test completed successfully" "$log_file"; then
  echo "PASS: see $log_file"
  exit 0
else
  echo "FAIL: see $log_file"
  exit 1
fi
